//--- countConnected.f
hw/countConnectedPkg.sv
hw/seedFinder.sv
hw/regionExplorer.sv
hw/countControl.sv
hw/countConnectedTop.sv
tb/countConnectedTb.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f countConnected.f \
    --top-module countConnectedTb \
    -Mdir obj_dir -o simv
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/simv
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0

//--- tb/countConnectedTb.sv
module countConnectedTb;
    timeunit 1ns;
    timeprecision 1ps;

    import countConnectedPkg::*;

    localparam int clkPeriod = 4;
    // five directed, forty random, one locked-register job, one irq job
    localparam int numJobs = 47;
    localparam int jobCycles = 64 * 20 + 100;
    localparam int timeoutNs = numJobs * jobCycles * clkPeriod + 2000;

    logic   clk;
    logic   rst;
    apbReqT apbReq;
    apbRspT apbRsp;
    logic   irq;

    logic [31:0] lfsrState = 32'h5b1f;
    logic [31:0] expCount = '0;
    logic        jobPending = 1'b0;

    countConnectedTop countConnectedTop_inst (
        .clk    (clk),
        .rst    (rst),
        .apbReq (apbReq),
        .apbRsp (apbRsp),
        .irq    (irq)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // galois form, taps of a maximal 32-bit polynomial
    function automatic logic [31:0] stepLfsr(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hB4BC_D35C) : (s >> 1);
    endfunction

    function automatic logic takeBit();
        logic b;
        b = lfsrState[0];
        lfsrState = stepLfsr(lfsrState);
        return b;
    endfunction

    // dense vectors OR several bits, sparse ones AND them
    function automatic graphT randomGraph();
        graphT g;
        logic  dense;
        logic  b;
        int    k;
        dense = takeBit();
        k = 1 + 2 * takeBit();
        k = k + takeBit();
        for (int i = 0; i < graphW; i++) begin
            b = takeBit();
            for (int j = 1; j < k; j++) begin
                b = dense ? (b | takeBit()) : (b & takeBit());
            end
            g[i] = b;
        end
        return g;
    endfunction

    // one region starts at every rising edge, bit -1 counts as zero
    function automatic logic [31:0] refCount(input graphT g);
        logic [31:0] n;
        logic        prev;
        n = 0;
        prev = 1'b0;
        for (int i = 0; i < graphW; i++) begin
            if (g[i] && !prev) begin
                n = n + 1;
            end
            prev = g[i];
        end
        return n;
    endfunction

    function automatic graphT makeRun(input int lo, input int hi);
        graphT g;
        g = '0;
        for (int i = lo; i <= hi; i++) begin
            g[i] = 1'b1;
        end
        return g;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            $display("test failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // setup cycle then access cycle, sampled while the access phase is stable
    task automatic apbTransfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                               output logic [31:0] rdata, output logic err);
        @(negedge clk);
        apbReq.psel    = 1'b1;
        apbReq.penable = 1'b0;
        apbReq.pwrite  = wr;
        apbReq.paddr   = addr;
        apbReq.pwdata  = wdata;
        @(negedge clk);
        apbReq.penable = 1'b1;
        #1;
        rdata = apbRsp.prdata;
        err   = apbRsp.pslverr;
        checkValue("pready", {31'd0, apbRsp.pready}, 1);
        @(negedge clk);
        apbReq = '0;
    endtask

    task automatic apbWrite(input logic [7:0] addr, input logic [31:0] wdata, output logic err);
        logic [31:0] unused;
        apbTransfer(1'b1, addr, wdata, unused, err);
    endtask

    task automatic apbRead(input logic [7:0] addr, output logic [31:0] rdata, output logic err);
        apbTransfer(1'b0, addr, '0, rdata, err);
    endtask

    task automatic writeGraph(input graphT g);
        logic err;
        for (int w = 0; w < 4; w++) begin
            apbWrite(8'(4 * w), g[32*w +: 32], err);
            checkValue("pslverr", {31'd0, err}, 0);
        end
    endtask

    task automatic startJob();
        logic err;
        apbWrite(ctrlAddr, 32'd1, err);
        checkValue("pslverr", {31'd0, err}, 0);
    endtask

    // hand the expected count to the compare process and wait for it
    task automatic awaitResult(input graphT g);
        expCount = refCount(g);
        jobPending = 1'b1;
        wait (!jobPending);
    endtask

    task automatic runJob(input graphT g);
        writeGraph(g);
        startJob();
        awaitResult(g);
    endtask

    initial begin : compareResults
        logic [31:0] rd;
        logic        err;
        forever begin
            wait (jobPending);
            wait (irq);
            apbRead(countAddr, rd, err);
            checkValue("count", rd, expCount);
            checkValue("pslverr", {31'd0, err}, 0);
            jobPending = 1'b0;
        end
    end

    initial begin
        #(timeoutNs);
        $display("run timed out at %0t, a job never raised irq", $time);
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin : mainSequence
        logic [31:0] rd;
        logic        err;
        graphT       g;
        apbReq = '0;
        rst = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        apbRead(ctrlAddr, rd, err);
        checkValue("status", rd, 0);
        apbRead(countAddr, rd, err);
        checkValue("count", rd, 0);
        checkValue("irq", {31'd0, irq}, 0);

        runJob('0);
        runJob('1);
        runJob({32{4'h5}});
        runJob(makeRun(127, 127));
        // runs across 4-, 16- and 64-bit group boundaries
        g = makeRun(2, 5) | makeRun(14, 18) | makeRun(31, 33) | makeRun(60, 70)
            | makeRun(79, 80) | makeRun(95, 112) | makeRun(124, 127);
        runJob(g);

        for (int n = 0; n < 40; n++) begin
            runJob(randomGraph());
        end

        // graph and ctrl are locked while busy
        g = {32{4'h3}};
        writeGraph(g);
        startJob();
        apbWrite(graphAddr0, ~g[31:0], err);
        checkValue("pslverr", {31'd0, err}, 1);
        apbWrite(ctrlAddr, 32'd1, err);
        checkValue("pslverr", {31'd0, err}, 1);
        awaitResult(g);
        apbRead(graphAddr0, rd, err);
        checkValue("graphWord0", rd, g[31:0]);

        apbRead(8'h18, rd, err);
        checkValue("pslverr", {31'd0, err}, 1);
        checkValue("prdata", rd, 0);
        apbWrite(8'h20, 32'hFFFF_FFFF, err);
        checkValue("pslverr", {31'd0, err}, 1);
        apbWrite(countAddr, 32'd5, err);
        checkValue("pslverr", {31'd0, err}, 1);
        apbRead(countAddr, rd, err);
        checkValue("count", rd, refCount(g));

        // irq holds until the next start, then drops while busy
        repeat (5) @(negedge clk);
        checkValue("irq", {31'd0, irq}, 1);
        apbRead(ctrlAddr, rd, err);
        checkValue("status", rd, 2);
        g = {32{4'hA}};
        writeGraph(g);
        checkValue("irq", {31'd0, irq}, 1);
        startJob();
        apbRead(ctrlAddr, rd, err);
        checkValue("status", rd, 1);
        checkValue("irq", {31'd0, irq}, 0);
        awaitResult(g);

        $display("test passed");
        $finish;
    end

endmodule

//--- hw/countConnectedTop.sv
module countConnectedTop (
    input  logic                       clk,
    input  logic                       rst,
    input  countConnectedPkg::apbReqT  apbReq,
    output countConnectedPkg::apbRspT  apbRsp,
    output logic                       irq
);
    import countConnectedPkg::*;

    logic      seedReq;
    logic      exploreReq;
    graphT     leftover;
    graphT     seed;
    seedResT   seedRes;
    regionResT regionRes;

    countControl countControl_inst (
        .clk        (clk),
        .rst        (rst),
        .apbReq     (apbReq),
        .apbRsp     (apbRsp),
        .irq        (irq),
        .seedReq    (seedReq),
        .leftover   (leftover),
        .seedRes    (seedRes),
        .exploreReq (exploreReq),
        .seed       (seed),
        .regionRes  (regionRes)
    );

    seedFinder seedFinder_inst (
        .clk      (clk),
        .rst      (rst),
        .seedReq  (seedReq),
        .leftover (leftover),
        .seedRes  (seedRes)
    );

    regionExplorer regionExplorer_inst (
        .clk        (clk),
        .rst        (rst),
        .exploreReq (exploreReq),
        .seed       (seed),
        .leftover   (leftover),
        .regionRes  (regionRes)
    );

endmodule

//--- hw/countControl.sv
module countControl (
    input  logic                          clk,
    input  logic                          rst,
    input  countConnectedPkg::apbReqT     apbReq,
    output countConnectedPkg::apbRspT     apbRsp,
    output logic                          irq,
    output logic                          seedReq,
    output countConnectedPkg::graphT      leftover,
    input  countConnectedPkg::seedResT    seedRes,
    output logic                          exploreReq,
    output countConnectedPkg::graphT      seed,
    input  countConnectedPkg::regionResT  regionRes
);
    import countConnectedPkg::*;

    typedef enum logic [2:0] {
        idle,
        seeding,
        waitSeed,
        exploring,
        finish
    } stateT;

    stateT       state;
    logic        busy;
    logic        done;
    countT       count;
    graphT       graphReg;

    logic        access;
    logic        addrHit;
    logic        isGraphAddr;
    logic        apbErr;
    logic        wrOk;
    logic        startJob;
    logic [31:0] readData;

    assign access = apbReq.psel && apbReq.penable;
    assign busy   = (state == seeding) || (state == waitSeed) || (state == exploring);

    // register decode and read mux
    always_comb begin
        addrHit     = 1'b1;
        isGraphAddr = 1'b0;
        readData    = '0;
        case (apbReq.paddr)
            graphAddr0: begin
                isGraphAddr = 1'b1;
                readData    = graphReg[31:0];
            end
            graphAddr1: begin
                isGraphAddr = 1'b1;
                readData    = graphReg[63:32];
            end
            graphAddr2: begin
                isGraphAddr = 1'b1;
                readData    = graphReg[95:64];
            end
            graphAddr3: begin
                isGraphAddr = 1'b1;
                readData    = graphReg[127:96];
            end
            ctrlAddr: readData = {30'd0, done, busy};
            countAddr: readData = {{(32-countW){1'b0}}, count};
            default: addrHit = 1'b0;
        endcase
    end

    // count is read only, graph and ctrl are locked during a job
    assign apbErr = !addrHit
        || (apbReq.pwrite && apbReq.paddr == countAddr)
        || (apbReq.pwrite && busy && (isGraphAddr || apbReq.paddr == ctrlAddr));
    assign wrOk     = access && apbReq.pwrite && !apbErr;
    assign startJob = wrOk && apbReq.paddr == ctrlAddr && apbReq.pwdata[0];

    assign apbRsp = '{prdata: readData, pready: 1'b1, pslverr: access && apbErr};

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= idle;
            done     <= 1'b0;
            count    <= '0;
            graphReg <= '0;
        end else begin
            if (wrOk && isGraphAddr) begin
                graphReg[32*apbReq.paddr[3:2] +: 32] <= apbReq.pwdata;
            end
            case (state)
                idle, finish: begin
                    if (startJob) begin
                        state <= seeding;
                        done  <= 1'b0;
                        count <= '0;
                    end else begin
                        state <= idle;
                    end
                end
                seeding: state <= waitSeed;
                waitSeed: begin
                    if (seedRes.valid) begin
                        if (seedRes.empty) begin
                            state <= finish;
                            done  <= 1'b1;
                        end else begin
                            state <= exploring;
                            count <= count + 1'b1;
                        end
                    end
                end
                exploring: begin
                    if (regionRes.valid) begin
                        state <= seeding;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // leftover shrinks by one region per explore round
    always_ff @(posedge clk) begin
        if (startJob) begin
            leftover <= graphReg;
        end else if (state == exploring && regionRes.valid) begin
            leftover <= leftover & ~regionRes.region;
        end
    end

    assign seedReq    = (state == seeding);
    assign exploreReq = (state == waitSeed) && seedRes.valid && !seedRes.empty;
    assign seed       = seedRes.seed;
    assign irq        = done;

    oneRequestAtATime: assert property (@(posedge clk) disable iff (rst)
        !(seedReq && exploreReq));

    regionOnlyWhileExploring: assert property (@(posedge clk) disable iff (rst)
        regionRes.valid |-> state == exploring);

endmodule

//--- hw/regionExplorer.sv
module regionExplorer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          exploreReq,
    input  countConnectedPkg::graphT      seed,
    input  countConnectedPkg::graphT      leftover,
    output countConnectedPkg::regionResT  regionRes
);
    import countConnectedPkg::*;

    logic  busy;
    logic  resValid;
    graphT region;
    graphT held;
    graphT grown;

    // three masked doubling steps toward higher bits
    function automatic graphT growUp(input graphT r, input graphT h);
        graphT g;
        graphT p;
        g = r | ((r << 1) & h);
        p = h & (h << 1);
        g = g | ((g << 2) & p);
        p = p & (p << 2);
        g = g | ((g << 4) & p);
        return g;
    endfunction

    // same growth toward lower bits
    function automatic graphT growDown(input graphT r, input graphT h);
        graphT g;
        graphT p;
        g = r | ((r >> 1) & h);
        p = h & (h >> 1);
        g = g | ((g >> 2) & p);
        p = p & (p >> 2);
        g = g | ((g >> 4) & p);
        return g;
    endfunction

    assign grown = growUp(region, held) | growDown(region, held);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            resValid <= 1'b0;
        end else begin
            resValid <= 1'b0;
            if (exploreReq) begin
                busy <= 1'b1;
            end else if (busy && grown == region) begin
                // nothing added this iteration
                busy     <= 1'b0;
                resValid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (exploreReq) begin
            region <= seed;
            held   <= leftover;
        end else if (busy) begin
            region <= grown;
        end
    end

    assign regionRes = '{valid: resValid, region: region};

    regionInLeftover: assert property (@(posedge clk) disable iff (rst)
        (busy || resValid) |-> ((region & ~held) == '0));

endmodule

//--- hw/seedFinder.sv
module seedFinder (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        seedReq,
    input  countConnectedPkg::graphT    leftover,
    output countConnectedPkg::seedResT  seedRes
);
    import countConnectedPkg::*;

    // any-set flags per 4-bit group, 16-bit group and 64-bit half
    logic [31:0] hasBit4;
    logic [7:0]  hasBit16;
    logic [1:0]  hasBit64;
    // first flagged group within each set of four
    logic [31:0] firstBit4;
    logic [7:0]  firstBit16;

    logic [1:0]  hasBit64D;
    logic [31:0] firstBit4D;
    logic [7:0]  firstBit16D;
    graphT       vecD;
    logic        validD;

    logic [31:0] groupSel;
    graphT       seedVec;

    // keeps only the lowest set bit of four
    function automatic logic [3:0] lowestOfFour(input logic [3:0] f);
        return f & (~f + 4'd1);
    endfunction

    always_comb begin
        for (int i = 0; i < 32; i++) begin
            hasBit4[i] = |leftover[4*i +: 4];
        end
        for (int i = 0; i < 8; i++) begin
            hasBit16[i] = |hasBit4[4*i +: 4];
            firstBit4[4*i +: 4] = lowestOfFour(hasBit4[4*i +: 4]);
        end
        for (int i = 0; i < 2; i++) begin
            hasBit64[i] = |hasBit16[4*i +: 4];
            firstBit16[4*i +: 4] = lowestOfFour(hasBit16[4*i +: 4]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            validD <= 1'b0;
        end else begin
            validD <= seedReq;
        end
    end

    always_ff @(posedge clk) begin
        if (seedReq) begin
            hasBit64D   <= hasBit64;
            firstBit4D  <= firstBit4;
            firstBit16D <= firstBit16;
            vecD        <= leftover;
        end
    end

    // upper half only counts when the lower half is clear
    always_comb begin
        for (int g = 0; g < 32; g++) begin
            groupSel[g] = firstBit4D[g] && firstBit16D[g/4] && (g < 16 || !hasBit64D[0]);
            seedVec[4*g +: 4] = groupSel[g] ? lowestOfFour(vecD[4*g +: 4]) : 4'b0000;
        end
    end

    assign seedRes = '{valid: validD, empty: !(|hasBit64D), seed: seedVec};

    seedIsLowestBit: assert property (@(posedge clk) disable iff (rst)
        seedReq |=> seedRes.valid && $onehot0(seedRes.seed)
            && ((seedRes.seed & ~$past(leftover)) == '0)
            && (seedRes.empty == ($past(leftover) == '0)));

endmodule

//--- hw/countConnectedPkg.sv
package countConnectedPkg;

    // occupancy vector and result widths
    localparam int graphW = 128;
    localparam int countW = 7;

    typedef logic [graphW-1:0] graphT;
    typedef logic [countW-1:0] countT;

    // APB word addresses, graph word 0 holds bits 31:0
    localparam logic [7:0] graphAddr0 = 8'h00;
    localparam logic [7:0] graphAddr1 = 8'h04;
    localparam logic [7:0] graphAddr2 = 8'h08;
    localparam logic [7:0] graphAddr3 = 8'h0C;
    localparam logic [7:0] ctrlAddr   = 8'h10;
    localparam logic [7:0] countAddr  = 8'h14;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apbReqT;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apbRspT;

    // empty is set when the leftover vector had no set bit
    typedef struct packed {
        logic  valid;
        logic  empty;
        graphT seed;
    } seedResT;

    typedef struct packed {
        logic  valid;
        graphT region;
    } regionResT;

endpackage
